//--- rtl/tay_exp_pkg.sv
// shared widths, float types and series constants for the taylor e^x engine
package tay_exp_pkg;

	//////////////////////////////
	// float format 1-8-7
	//////////////////////////////

	localparam int FP_W     = 16;
	localparam int EXP_W    = 8;
	localparam int FRAC_W   = 7;
	// mantissa incl. hidden bit
	localparam int MANT_W   = FRAC_W + 1;
	// mantissa + guard, round, sticky
	localparam int GRS_W    = MANT_W + 3;
	localparam int EXP_BIAS = 127;

	// approximation level, 1..7
	localparam int LEVEL_W  = 3;

	//////////////////////////////
	// types
	//////////////////////////////

	typedef logic [FP_W-1:0]    fp_t;
	typedef logic [GRS_W-1:0]   mant_ext_t;
	typedef logic [LEVEL_W-1:0] level_t;

	//////////////////////////////
	// constants
	//////////////////////////////

	// 1.0: exponent equal to the bias, empty fraction
	localparam fp_t FP_ONE = 16'h3F80;

	// 1/k! for k = 2..7, rounded to nearest even
	// entry n holds 1/(n+2)!
	localparam fp_t RECIP_FACT [0:5] = '{
		16'h3F00,	// 1/2
		16'h3E2B,	// 1/6
		16'h3D2B,	// 1/24
		16'h3C09,	// 1/120
		16'h3AB6,	// 1/720
		16'h3950	// 1/5040
	};

endpackage

//--- rtl/fp_operand_if.sv
// unpacked operand pair and issue strobes from the unpack stage to the arithmetic units
`timescale 1ns/100ps

interface fp_operand_if import tay_exp_pkg::*;;

	// one-cycle strobes, never both high
	logic              do_add;
	logic              do_mul;

	// operand a
	logic              a_sign;
	logic [EXP_W-1:0]  a_exp;
	logic [MANT_W-1:0] a_mant;
	logic              a_zero;

	// operand b
	logic              b_sign;
	logic [EXP_W-1:0]  b_exp;
	logic [MANT_W-1:0] b_mant;
	logic              b_zero;

	modport unpack (output do_add, do_mul, a_sign, a_exp, a_mant, a_zero,
		b_sign, b_exp, b_mant, b_zero);
	modport unit (input do_add, do_mul, a_sign, a_exp, a_mant, a_zero,
		b_sign, b_exp, b_mant, b_zero);

endinterface

//--- rtl/fp_result_if.sv
// unrounded unit result with guard bits, carried from an arithmetic unit to the rounder
`timescale 1ns/100ps

interface fp_result_if import tay_exp_pkg::*; (
	input logic clk,
	input logic rst
);

	// one-cycle strobe
	logic             valid;
	logic             sign;
	logic [EXP_W-1:0] exp;
	// hidden bit, fraction, then g/r/s
	mant_ext_t        mant;

	modport unit (output valid, sign, exp, mant);
	// clk/rst only for checks on the rounder side
	modport round (input clk, rst, valid, sign, exp, mant);

endinterface

//--- rtl/fp_unpack_stage.sv
// operand unpack stage, splits both floats and registers fields and strobes for one cycle
`timescale 1ns/100ps

module fp_unpack_stage import tay_exp_pkg::*; (
	input  logic clk,
	input  logic rst,
	input  fp_t  op_a_i,
	input  fp_t  op_b_i,
	input  logic issue_add_i,
	input  logic issue_mul_i,
	fp_operand_if.unpack opnd
);

	logic a_zero_w;
	logic b_zero_w;

	// zero exponent means zero, denormals included
	assign a_zero_w = (op_a_i[FP_W-2 -: EXP_W] == '0);
	assign b_zero_w = (op_b_i[FP_W-2 -: EXP_W] == '0);

	// strobes
	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			opnd.do_add <= 1'b0;
			opnd.do_mul <= 1'b0;
		end
		else
		begin
			opnd.do_add <= issue_add_i;
			opnd.do_mul <= issue_mul_i;
		end
	end

	// operand fields, hidden bit restored unless zero
	always_ff @(posedge clk)
	begin
		if (issue_add_i || issue_mul_i)
		begin
			opnd.a_sign <= op_a_i[FP_W-1];
			opnd.a_exp  <= op_a_i[FP_W-2 -: EXP_W];
			opnd.a_mant <= a_zero_w ? '0 : {1'b1, op_a_i[FRAC_W-1:0]};
			opnd.a_zero <= a_zero_w;
			opnd.b_sign <= op_b_i[FP_W-1];
			opnd.b_exp  <= op_b_i[FP_W-2 -: EXP_W];
			opnd.b_mant <= b_zero_w ? '0 : {1'b1, op_b_i[FRAC_W-1:0]};
			opnd.b_zero <= b_zero_w;
		end
	end

	// an issue reaches exactly one unit on the next cycle
	a_one_unit: assert property (@(posedge clk) disable iff (rst)
		(issue_add_i || issue_mul_i) |=> (opnd.do_add != opnd.do_mul));

endmodule

//--- rtl/fp_add_unit.sv
// float adder, aligns by exponent, adds or subtracts magnitudes and normalizes with g/r/s bits
`timescale 1ns/100ps

module fp_add_unit import tay_exp_pkg::*; (
	input  logic clk,
	input  logic rst,
	fp_operand_if.unit opnd,
	fp_result_if.unit  res
);

	logic                      a_ge_b;
	logic                      big_sign;
	logic [EXP_W-1:0]          big_exp;
	logic [MANT_W-1:0]         big_mant;
	logic [EXP_W-1:0]          small_exp;
	logic [MANT_W-1:0]         small_mant;
	logic [EXP_W-1:0]          exp_diff;
	logic [MANT_W+GRS_W-1:0]   small_wide;
	mant_ext_t                 big_ext;
	mant_ext_t                 small_ext;
	logic [GRS_W:0]            raw_sum;
	logic [3:0]                lzc;
	logic                      sum_sign;
	logic [EXP_W-1:0]          sum_exp;
	mant_ext_t                 sum_mant;

	//////////////////////////////
	// order and align
	//////////////////////////////

	// compare exponent first, then mantissa
	assign a_ge_b     = {opnd.a_exp, opnd.a_mant} >= {opnd.b_exp, opnd.b_mant};
	assign big_sign   = a_ge_b ? opnd.a_sign : opnd.b_sign;
	assign big_exp    = a_ge_b ? opnd.a_exp  : opnd.b_exp;
	assign big_mant   = a_ge_b ? opnd.a_mant : opnd.b_mant;
	assign small_exp  = a_ge_b ? opnd.b_exp  : opnd.a_exp;
	assign small_mant = a_ge_b ? opnd.b_mant : opnd.a_mant;
	assign exp_diff   = big_exp - small_exp;

	// shift smaller right, lost bits fold into sticky
	assign small_wide = {small_mant, {GRS_W{1'b0}}} >> exp_diff;
	assign small_ext  = {small_wide[MANT_W+GRS_W-1 -: GRS_W-1], |small_wide[MANT_W:0]};
	assign big_ext    = {big_mant, {(GRS_W-MANT_W){1'b0}}};

	// same signs add, different signs subtract (big >= small)
	assign raw_sum = (opnd.a_sign == opnd.b_sign) ? ({1'b0, big_ext} + {1'b0, small_ext})
		: ({1'b0, big_ext} - {1'b0, small_ext});

	//////////////////////////////
	// normalize
	//////////////////////////////

	// leading zeros below the carry bit, highest set bit wins
	always_comb
	begin
		lzc = '0;
		for (int i = 0; i < GRS_W; i++)
			if (raw_sum[i])
				lzc = 4'(GRS_W - 1 - i);
	end

	always_comb
	begin
		sum_sign = big_sign;
		if (raw_sum == '0)
		begin
			// exact zero, e.g. x + (-x)
			sum_sign = 1'b0;
			sum_exp  = '0;
			sum_mant = '0;
		end
		else if (raw_sum[GRS_W])
		begin
			// carry out, one right
			sum_exp  = big_exp + 1'b1;
			sum_mant = {raw_sum[GRS_W:2], raw_sum[1] | raw_sum[0]};
		end
		else
		begin
			sum_exp  = big_exp - EXP_W'(lzc);
			sum_mant = raw_sum[GRS_W-1:0] << lzc;
		end
	end

	// result register
	always_ff @(posedge clk)
	begin
		if (rst)
			res.valid <= 1'b0;
		else
			res.valid <= opnd.do_add;
	end

	always_ff @(posedge clk)
	begin
		if (opnd.do_add)
		begin
			res.sign <= sum_sign;
			res.exp  <= sum_exp;
			res.mant <= sum_mant;
		end
	end

endmodule

//--- rtl/fp_mul_unit.sv
// float multiplier, mantissa product with exponent sum, one-step normalize with g/r/s bits
`timescale 1ns/100ps

module fp_mul_unit import tay_exp_pkg::*; (
	input  logic clk,
	input  logic rst,
	fp_operand_if.unit opnd,
	fp_result_if.unit  res
);

	logic [2*MANT_W-1:0] prod;
	logic [EXP_W+1:0]    exp_sum;
	logic                any_zero;
	mant_ext_t           prod_ext;

	// 1.x * 1.y lies in [1, 4)
	assign prod     = opnd.a_mant * opnd.b_mant;
	assign any_zero = opnd.a_zero || opnd.b_zero;

	// rebias, plus one when the product is >= 2
	assign exp_sum = {2'b00, opnd.a_exp} + {2'b00, opnd.b_exp}
		- (EXP_W+2)'(EXP_BIAS) + (EXP_W+2)'(prod[2*MANT_W-1]);

	// keep 10 bits, the rest into sticky
	assign prod_ext = prod[2*MANT_W-1]
		? {prod[2*MANT_W-1 -: GRS_W-1], |prod[MANT_W-3:0]}
		: {prod[2*MANT_W-2 -: GRS_W-1], |prod[MANT_W-4:0]};

	always_ff @(posedge clk)
	begin
		if (rst)
			res.valid <= 1'b0;
		else
			res.valid <= opnd.do_mul;
	end

	// zero operand forces a clean +0
	always_ff @(posedge clk)
	begin
		if (opnd.do_mul)
		begin
			res.sign <= any_zero ? 1'b0 : (opnd.a_sign ^ opnd.b_sign);
			res.exp  <= any_zero ? '0 : exp_sum[EXP_W-1:0];
			res.mant <= any_zero ? '0 : prod_ext;
		end
	end

endmodule

//--- rtl/fp_round_pack.sv
// result select, round to nearest even and packing into a 16-bit float
`timescale 1ns/100ps

module fp_round_pack import tay_exp_pkg::*; (
	fp_result_if.round add_res,
	fp_result_if.round mul_res,
	output fp_t  rounded_o,
	output logic rounded_valid_o
);

	logic             sel_sign;
	logic [EXP_W-1:0] sel_exp;
	mant_ext_t        sel_mant;
	logic             rnd_up;
	logic [MANT_W:0]  mant_rnd;
	logic [EXP_W-1:0] exp_out;
	logic [FRAC_W-1:0] frac_out;

	// whichever unit finished this cycle
	assign sel_sign = add_res.valid ? add_res.sign : mul_res.sign;
	assign sel_exp  = add_res.valid ? add_res.exp  : mul_res.exp;
	assign sel_mant = add_res.valid ? add_res.mant : mul_res.mant;

	// g & (r | s | lsb), ties go to even
	assign rnd_up   = sel_mant[2] & (sel_mant[1] | sel_mant[0] | sel_mant[3]);
	assign mant_rnd = {1'b0, sel_mant[GRS_W-1 -: MANT_W]} + (MANT_W+1)'(rnd_up);

	// 1.111.. + ulp wraps to 10.000.., bump exponent
	assign exp_out  = mant_rnd[MANT_W] ? sel_exp + 1'b1 : sel_exp;
	assign frac_out = mant_rnd[MANT_W] ? mant_rnd[FRAC_W:1] : mant_rnd[FRAC_W-1:0];

	assign rounded_o       = {sel_sign, exp_out, frac_out};
	assign rounded_valid_o = add_res.valid || mul_res.valid;

	// the sequencer keeps a single operation in flight
	a_one_valid: assert property (@(posedge add_res.clk) disable iff (add_res.rst)
		!(add_res.valid && mul_res.valid));

endmodule

//--- rtl/tay_exp_sequencer.sv
// taylor series FSM that issues add/mul steps for e^x and holds the final result until acked
`timescale 1ns/100ps

module tay_exp_sequencer import tay_exp_pkg::*; (
	input  logic   clk,
	input  logic   rst,
	input  logic   valid_i,
	input  level_t level_i,
	input  fp_t    op_i,
	input  logic   result_ack_i,
	input  fp_t    rounded_i,
	input  logic   rounded_valid_i,
	output fp_t    op_a_o,
	output fp_t    op_b_o,
	output logic   issue_add_o,
	output logic   issue_mul_o,
	output fp_t    result_o,
	output logic   result_valid_o,
	output logic   ready_o
);

	typedef enum logic [1:0] {IDLE, ITER, DONE} seq_state_t;
	typedef enum logic [1:0] {PWR, FACT, SUM} iter_step_t;

	seq_state_t ss, ss_next;
	iter_step_t step, step_next;
	level_t     iter_r, iter_next;
	level_t     level_r, level_next;
	fp_t        x_r, x_next;
	fp_t        pwr_r, pwr_next;
	fp_t        sum_r, sum_next;
	fp_t        result_next;
	logic       result_valid_next;
	logic       accept;

	// requests only taken from IDLE
	assign accept  = valid_i && (ss == IDLE);
	assign ready_o = (ss == IDLE) || result_valid_o;

	//////////////////////////////
	// registers
	//////////////////////////////

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			ss             <= IDLE;
			step           <= PWR;
			iter_r         <= '0;
			result_o       <= '0;
			result_valid_o <= 1'b0;
		end
		else
		begin
			ss             <= ss_next;
			step           <= step_next;
			iter_r         <= iter_next;
			result_o       <= result_next;
			result_valid_o <= result_valid_next;
		end
	end

	// series operands
	always_ff @(posedge clk)
	begin
		x_r     <= x_next;
		pwr_r   <= pwr_next;
		sum_r   <= sum_next;
		level_r <= level_next;
	end

	//////////////////////////////
	// next state and issue
	//////////////////////////////

	always_comb
	begin
		ss_next           = ss;
		step_next         = step;
		iter_next         = iter_r;
		level_next        = level_r;
		x_next            = x_r;
		pwr_next          = pwr_r;
		sum_next          = sum_r;
		result_next       = result_o;
		result_valid_next = result_valid_o;
		op_a_o            = '0;
		op_b_o            = '0;
		issue_add_o       = 1'b0;
		issue_mul_o       = 1'b0;
		case (ss)
			IDLE:
			begin
				if (accept)
				begin
					// first op is 1 + x
					op_a_o      = FP_ONE;
					op_b_o      = op_i;
					issue_add_o = 1'b1;
					x_next      = op_i;
					pwr_next    = op_i;
					level_next  = level_i;
					iter_next   = 3'd1;
					step_next   = PWR;
					ss_next     = ITER;
				end
			end
			ITER:
			begin
				if (rounded_valid_i && (iter_r == level_r))
				begin
					result_next       = rounded_i;
					result_valid_next = 1'b1;
					ss_next           = DONE;
				end
				else if (rounded_valid_i)
				begin
					case (step)
						PWR:
						begin
							// store partial sum and form x^(i+1) = x * x^i
							sum_next    = rounded_i;
							op_a_o      = x_r;
							op_b_o      = pwr_r;
							issue_mul_o = 1'b1;
							step_next   = FACT;
						end
						FACT:
						begin
							// term = x^(i+1) / (i+1)!
							pwr_next    = rounded_i;
							op_a_o      = rounded_i;
							op_b_o      = RECIP_FACT[iter_r - 3'd1];
							issue_mul_o = 1'b1;
							step_next   = SUM;
						end
						default:
						begin
							op_a_o      = rounded_i;
							op_b_o      = sum_r;
							issue_add_o = 1'b1;
							iter_next   = iter_r + 3'd1;
							step_next   = PWR;
						end
					endcase
				end
			end
			default:
			begin
				// hold result until acked
				if (result_ack_i)
				begin
					result_valid_next = 1'b0;
					ss_next           = IDLE;
				end
			end
		endcase
	end

	a_level_nz: assert property (@(posedge clk) disable iff (rst)
		accept |-> (level_i != '0));

	// at most one operation in flight at a time
	a_one_in_flight: assert property (@(posedge clk) disable iff (rst)
		(issue_add_o || issue_mul_o) |=> !(issue_add_o || issue_mul_o));

endmodule

//--- rtl/tay_exp_top.sv
// top level of the taylor e^x engine, sequencer plus unpack, add, mul and round stages
`timescale 1ns/100ps

module tay_exp_top import tay_exp_pkg::*; (
	input  logic   clk,
	input  logic   rst,
	input  logic   valid_i,
	input  level_t level_i,
	input  fp_t    op_i,
	input  logic   result_ack_i,
	output fp_t    result_o,
	output logic   result_valid_o,
	output logic   ready_o
);

	fp_t  op_a;
	fp_t  op_b;
	logic issue_add;
	logic issue_mul;
	fp_t  rounded;
	logic rounded_valid;

	fp_operand_if opnd_if ();
	fp_result_if  add_res_if (.clk(clk), .rst(rst));
	fp_result_if  mul_res_if (.clk(clk), .rst(rst));

	tay_exp_sequencer seq0 (
		.clk(clk), .rst(rst),
		.valid_i(valid_i), .level_i(level_i), .op_i(op_i), .result_ack_i(result_ack_i),
		.rounded_i(rounded), .rounded_valid_i(rounded_valid),
		.op_a_o(op_a), .op_b_o(op_b), .issue_add_o(issue_add), .issue_mul_o(issue_mul),
		.result_o(result_o), .result_valid_o(result_valid_o), .ready_o(ready_o)
	);

	fp_unpack_stage unpack0 (
		.clk(clk), .rst(rst), .op_a_i(op_a), .op_b_i(op_b),
		.issue_add_i(issue_add), .issue_mul_i(issue_mul), .opnd(opnd_if)
	);

	fp_add_unit add0 (.clk(clk), .rst(rst), .opnd(opnd_if), .res(add_res_if));
	fp_mul_unit mul0 (.clk(clk), .rst(rst), .opnd(opnd_if), .res(mul_res_if));

	fp_round_pack round0 (
		.add_res(add_res_if), .mul_res(mul_res_if),
		.rounded_o(rounded), .rounded_valid_o(rounded_valid)
	);

endmodule

//--- sim/tb_tay_exp.sv
// testbench for the taylor e^x engine, random requests checked against a real-valued series model
`timescale 1ns/100ps

module tb_tay_exp import tay_exp_pkg::*;;

	// requests per test
	localparam int N_ZERO   = 7;
	localparam int N_LVL1   = 12;
	localparam int N_RAND   = 30;
	localparam int N_MONO   = 7;
	localparam int N_HS     = 6;
	localparam int MAX_HOLD = 6;
	// worst request: level 7 latency, longest hold, handshake overhead
	localparam int REQ_CYC     = 6 * 7 + MAX_HOLD + 8;
	localparam int TIMEOUT_CYC = (N_ZERO + N_LVL1 + N_RAND + N_MONO + N_HS) * REQ_CYC + 100;
	// 2^-5 relative
	localparam real REL_TOL = 0.03125;

	logic   clk;
	logic   rst;
	logic   valid_i;
	level_t level_i;
	fp_t    op_i;
	logic   result_ack_i;
	fp_t    result_o;
	logic   result_valid_o;
	logic   ready_o;

	integer seed = 1916;
	int     cycle_cnt;
	int     checks;
	int     errors;
	int     test_checks;
	int     test_errors;
	int     req_cnt;
	int     res_cnt = 0;
	logic   rv_prev = 1'b0;
	string  test_name;

	tay_exp_top dut0 (
		.clk(clk), .rst(rst), .valid_i(valid_i), .level_i(level_i), .op_i(op_i),
		.result_ack_i(result_ack_i), .result_o(result_o),
		.result_valid_o(result_valid_o), .ready_o(ready_o)
	);

	initial
	begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	// rising edges of result_valid_o, one per result
	always @(posedge clk)
	begin
		if (result_valid_o && !rv_prev)
			res_cnt = res_cnt + 1;
		rv_prev = result_valid_o;
	end

	//////////////////////////////
	// model
	//////////////////////////////

	// 1-8-7 float to real, zero exponent reads as zero
	function automatic real fp_to_real(input fp_t f);
		real v;
		int  e;
		if (f[14:7] == 8'd0)
			return 0.0;
		v = 1.0 + f[6:0] / 128.0;
		for (e = f[14:7]; e < 127; e++)
			v = v / 2.0;
		for (e = f[14:7]; e > 127; e--)
			v = v * 2.0;
		return f[15] ? -v : v;
	endfunction

	// 1 + x + ... + x^lvl/lvl!
	function automatic real series_sum(input real x, input int lvl);
		real sum;
		real term;
		sum  = 1.0;
		term = 1.0;
		for (int k = 1; k <= lvl; k++)
		begin
			term = term * x / k;
			sum  = sum + term;
		end
		return sum;
	endfunction

	//////////////////////////////
	// helpers
	//////////////////////////////

	task automatic step_cycle();
		@(posedge clk);
		#1;
	endtask

	// |x| <= 1, exponent kept high enough that x^7/7! stays normal
	task automatic pick_operand(output fp_t x);
		logic [31:0] r;
		r = $random(seed);
		if (r[2:0] == 3'd0)
			x = {r[3], 8'd127, 7'd0};
		else
			x = {r[3], 8'd115 + 8'(r[15:8] % 12), r[22:16]};
	endtask

	task automatic start_test(input string name);
		test_name   = name;
		test_checks = checks;
		test_errors = errors;
	endtask

	task automatic end_test();
		$display("test %-12s %0d checks, %0d errors", test_name,
			checks - test_checks, errors - test_errors);
	endtask

	// one request, hold the result for a while, then ack
	task automatic run_request(input fp_t x, input level_t lvl, input int hold,
		input logic poke, output fp_t res);
		fp_t held;
		while (!ready_o)
			step_cycle();
		op_i    = x;
		level_i = lvl;
		valid_i = 1'b1;
		step_cycle();
		valid_i = 1'b0;
		req_cnt++;
		while (!result_valid_o)
			step_cycle();
		held = result_o;
		for (int i = 0; i < hold; i++)
		begin
			// competing request while the result waits
			if (poke)
			begin
				valid_i = 1'b1;
				op_i    = ~x;
				level_i = 3'd7;
			end
			step_cycle();
			checks++;
			if (!result_valid_o)
			begin
				errors++;
				$display("%s: result_valid_o dropped before acknowledge", test_name);
			end
			else if (result_o !== held)
			begin
				errors++;
				$display("MISMATCH %s held result expected=%h actual=%h", test_name,
					held, result_o);
			end
		end
		valid_i      = 1'b0;
		result_ack_i = 1'b1;
		step_cycle();
		result_ack_i = 1'b0;
		checks++;
		if (result_valid_o || !ready_o)
		begin
			errors++;
			$display("%s: DUT did not go back to idle after acknowledge", test_name);
		end
		res = held;
	endtask

	task automatic check_result(input fp_t x, input level_t lvl, input fp_t got,
		output real got_r);
		real exp_r;
		real err;
		real lim;
		exp_r = series_sum(fp_to_real(x), lvl);
		got_r = fp_to_real(got);
		err   = (got_r > exp_r) ? got_r - exp_r : exp_r - got_r;
		lim   = REL_TOL * ((exp_r < 0.0) ? -exp_r : exp_r);
		checks++;
		// zero x is exact
		if (x[14:7] == 8'd0)
		begin
			if (got !== 16'h3F80)
			begin
				errors++;
				$display("MISMATCH %s x=%h level=%0d expected=3f80 actual=%h", test_name,
					x, lvl, got);
			end
		end
		else if (err > lim)
		begin
			errors++;
			$display("MISMATCH %s x=%h level=%0d expected=%f actual=%f (%h)", test_name,
				x, lvl, exp_r, got_r, got);
		end
	endtask

	//////////////////////////////
	// tests
	//////////////////////////////

	initial
	begin
		fp_t         x;
		fp_t         got;
		real         got_r;
		real         prev_r;
		logic [31:0] r;
		rst          = 1'b1;
		valid_i      = 1'b0;
		level_i      = '0;
		op_i         = '0;
		result_ack_i = 1'b0;
		checks       = 0;
		errors       = 0;
		req_cnt      = 0;
		repeat (4) @(posedge clk);
		#1;
		rst = 1'b0;

		start_test("reset_state");
		checks++;
		if (!ready_o || result_valid_o || result_o !== '0)
		begin
			errors++;
			$display("%s: ready_o low or a result present after reset", test_name);
		end
		end_test();

		start_test("zero_input");
		for (int l = 1; l <= N_ZERO; l++)
		begin
			run_request(16'h0000, level_t'(l), 0, 1'b0, got);
			check_result(16'h0000, level_t'(l), got, got_r);
		end
		end_test();

		// adder alone
		start_test("level_one");
		for (int i = 0; i < N_LVL1; i++)
		begin
			pick_operand(x);
			r = $random(seed);
			run_request(x, 3'd1, int'(r % 3), 1'b0, got);
			check_result(x, 3'd1, got, got_r);
		end
		end_test();

		start_test("random_lvl");
		for (int i = 0; i < N_RAND; i++)
		begin
			pick_operand(x);
			r = $random(seed);
			run_request(x, level_t'(1 + r % 7), int'(r[15:8] % 3), 1'b0, got);
			check_result(x, level_t'(1 + r % 7), got, got_r);
		end
		end_test();

		// x = 0.75, every extra term is positive
		start_test("monotonic");
		prev_r = 0.0;
		for (int l = 1; l <= N_MONO; l++)
		begin
			run_request(16'h3F40, level_t'(l), 0, 1'b0, got);
			check_result(16'h3F40, level_t'(l), got, got_r);
			checks++;
			if (got_r < prev_r)
			begin
				errors++;
				$display("%s: result at level %0d fell below level %0d", test_name, l, l - 1);
			end
			prev_r = got_r;
		end
		end_test();

		// random ack delays with a second request pushed during the hold
		start_test("handshake");
		for (int i = 0; i < N_HS; i++)
		begin
			pick_operand(x);
			r = $random(seed);
			run_request(x, level_t'(1 + r % 7), 1 + int'(r[15:8] % MAX_HOLD), 1'b1, got);
			check_result(x, level_t'(1 + r % 7), got, got_r);
		end
		checks++;
		if (res_cnt != req_cnt)
		begin
			errors++;
			$display("%s: %0d results seen for %0d accepted requests", test_name,
				res_cnt, req_cnt);
		end
		end_test();

		$display("checks %0d, errors %0d", checks, errors);
		if (errors == 0)
			$display("*** PASSED ***");
		else
			$display("*** FAILED ***");
		$finish;
	end

	// run limit
	initial
	begin
		cycle_cnt = 0;
		while (cycle_cnt < TIMEOUT_CYC)
		begin
			@(posedge clk);
			cycle_cnt++;
		end
		$display("timeout: the tests did not finish within %0d cycles", cycle_cnt);
		$display("*** FAILED ***");
		$finish;
	end

endmodule

//--- list.f
rtl/tay_exp_pkg.sv
rtl/fp_operand_if.sv
rtl/fp_result_if.sv
rtl/fp_unpack_stage.sv
rtl/fp_add_unit.sv
rtl/fp_mul_unit.sv
rtl/fp_round_pack.sv
rtl/tay_exp_sequencer.sv
rtl/tay_exp_top.sv
sim/tb_tay_exp.sv

//--- run.sh
#!/usr/bin/env bash
# build and run the testbench with verilator, result taken from the log
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal --top-module tb_tay_exp -f list.f \
	-o tb_tay_exp > build.log 2>&1 \
	&& ./obj_dir/tb_tay_exp > sim.log 2>&1 \
	|| { echo "build or simulation run failed"; exit 1; }
grep -q '\*\*\* PASSED \*\*\*' sim.log && echo "simulation passed" \
	|| { echo "simulation failed, see sim.log"; exit 1; }
